// ==== all.f ====
rtl/cpu_pkg.sv
rtl/instr_decoder.sv
rtl/decode_stage.sv
rtl/hazard_unit.sv
rtl/execute_stage.sv
rtl/result_stage.sv
rtl/cpu_top.sv
verif/cpu_chk.sv
verif/tb_cpu.sv

// ==== rtl/cpu_pkg.sv ====
package cpu_pkg;

  //////////////////////////////////////////////////////////////////////
  // Widths and basic types

  localparam int WORD_W = 32;
  localparam int REG_AW = 5;

  typedef logic [WORD_W-1:0] word_t;
  typedef logic [31:0]       instr_t;
  typedef logic [REG_AW-1:0] reg_addr_t;
  typedef logic [5:0]        opcode_t;
  typedef logic [5:0]        funct_t;

  // Small enough for the six ops we keep
  typedef logic [2:0]        alu_op_t;

  //////////////////////////////////////////////////////////////////////
  // ALU operations

  localparam alu_op_t ALU_ADD = 3'd0;
  localparam alu_op_t ALU_SUB = 3'd1;
  localparam alu_op_t ALU_AND = 3'd2;
  localparam alu_op_t ALU_OR  = 3'd3;
  localparam alu_op_t ALU_SLT = 3'd4;
  // Immediate to upper half
  localparam alu_op_t ALU_LUI = 3'd5;

  //////////////////////////////////////////////////////////////////////
  // Instruction encodings

  // Major opcodes
  localparam opcode_t OP_SPECIAL = 6'b000000;
  localparam opcode_t OP_J       = 6'b000010;
  localparam opcode_t OP_JAL     = 6'b000011;
  localparam opcode_t OP_BEQ     = 6'b000100;
  localparam opcode_t OP_ORI     = 6'b001101;
  localparam opcode_t OP_LUI     = 6'b001111;

  // SPECIAL funct codes
  localparam funct_t FN_JR   = 6'b001000;
  localparam funct_t FN_ADDU = 6'b100001;
  localparam funct_t FN_SUBU = 6'b100011;
  localparam funct_t FN_AND  = 6'b100100;
  localparam funct_t FN_OR   = 6'b100101;
  localparam funct_t FN_SLT  = 6'b101010;

  // jal target register
  localparam reg_addr_t LINK_REG = 5'd31;

endpackage

// ==== rtl/cpu_top.sv ====
`timescale 1ns/1ps

module cpu_top import cpu_pkg::*; #(
  parameter word_t RESET_PC = 32'h0000_3000
) (
  input  logic      clk,
  input  logic      rst,
  input  instr_t    inst_rdata,
  output word_t     inst_addr,
  output logic      grf_we,
  output reg_addr_t grf_addr,
  output word_t     grf_wdata,
  output word_t     grf_pc
);

  // Decode to execute
  word_t     e_in_rs_val, e_in_rt_val, e_in_imm;
  word_t     e_in_link_val, e_in_pc;
  alu_op_t   e_in_alu_op;
  logic      e_in_b_is_imm, e_in_link;
  reg_addr_t e_in_wr_addr, e_in_rs, e_in_rt;

  // Hazard tracking
  reg_addr_t d_rs, d_rt;
  reg_addr_t e_rs, e_rt, e_wr_addr;
  logic      d_uses_rs, d_uses_rt, stall;
  logic      fwd_d_rs, fwd_d_rt, fwd_e_rs, fwd_e_rt;

  // Execute to result
  word_t     r_in_result, r_in_link_val, r_in_pc;
  reg_addr_t r_in_wr_addr;
  logic      r_in_link;

  // Register file reads and result bypass
  reg_addr_t rf_raddr1, rf_raddr2, res_wr_addr;
  word_t     rf_rdata1, rf_rdata2, res_wdata;

  decode_stage #(.RESET_PC(RESET_PC)) u_decode (
    .*,
    .fwd_rs (fwd_d_rs),
    .fwd_rt (fwd_d_rt)
  );

  hazard_unit u_hazard (.*);

  execute_stage u_execute (
    .*,
    .fwd_rs (fwd_e_rs),
    .fwd_rt (fwd_e_rt)
  );

  result_stage u_result (.*);

  // Trace shows the write in flight
  assign grf_addr  = res_wr_addr;
  assign grf_wdata = res_wdata;

endmodule

// ==== rtl/decode_stage.sv ====
`timescale 1ns/1ps

module decode_stage import cpu_pkg::*; #(
  parameter word_t RESET_PC = 32'h0000_3000
) (
  input  logic      clk,
  input  logic      rst,
  input  instr_t    inst_rdata,
  output word_t     inst_addr,
  input  logic      stall,
  input  word_t     rf_rdata1,
  input  word_t     rf_rdata2,
  output reg_addr_t rf_raddr1,
  output reg_addr_t rf_raddr2,
  input  logic      fwd_rs,
  input  logic      fwd_rt,
  input  word_t     res_wdata,
  output reg_addr_t d_rs,
  output reg_addr_t d_rt,
  output logic      d_uses_rs,
  output logic      d_uses_rt,
  output word_t     e_in_rs_val,
  output word_t     e_in_rt_val,
  output word_t     e_in_imm,
  output alu_op_t   e_in_alu_op,
  output logic      e_in_b_is_imm,
  output reg_addr_t e_in_wr_addr,
  output reg_addr_t e_in_rs,
  output reg_addr_t e_in_rt,
  output logic      e_in_link,
  output word_t     e_in_link_val,
  output word_t     e_in_pc
);

  word_t     pc;
  word_t     pc_next;
  instr_t    d_instr;
  word_t     d_pc;
  word_t     d_pc_plus4;
  word_t     rs_val;
  word_t     rt_val;
  word_t     imm_ext;
  word_t     beq_target;
  alu_op_t   alu_op;
  logic      b_is_imm;
  logic      imm_zero_ext;
  reg_addr_t wr_addr;
  logic      is_link;
  logic      is_beq;
  logic      is_jump;
  logic      is_jr;

  //////////////////////////////////////////////////////////////////////
  // Fetch: PC and fetch/decode register, both frozen by a stall

  always_ff @(posedge clk) begin
    if (rst) begin
      pc      <= RESET_PC;
      d_instr <= '0;
    end else if (!stall) begin
      pc      <= pc_next;
      d_instr <= inst_rdata;
    end
  end

  always_ff @(posedge clk) begin
    if (!stall) begin
      d_pc <= pc;
    end
  end

  assign inst_addr = pc;

  //////////////////////////////////////////////////////////////////////
  // Decode

  instr_decoder u_dec (
    .instr             (d_instr),
    .alu_op            (alu_op),
    .b_is_imm          (b_is_imm),
    .imm_zero_ext      (imm_zero_ext),
    .wr_addr           (wr_addr),
    .is_link           (is_link),
    .is_beq            (is_beq),
    .is_jump           (is_jump),
    .is_jr             (is_jr),
    .uses_rs_in_decode (d_uses_rs),
    .uses_rt_in_decode (d_uses_rt)
  );

  assign d_rs      = d_instr[25:21];
  assign d_rt      = d_instr[20:16];
  assign rf_raddr1 = d_rs;
  assign rf_raddr2 = d_rt;

  // Result stage has not written the file yet
  assign rs_val = fwd_rs ? res_wdata : rf_rdata1;
  assign rt_val = fwd_rt ? res_wdata : rf_rdata2;

  assign imm_ext = imm_zero_ext ? {16'h0000, d_instr[15:0]}
                                : {{16{d_instr[15]}}, d_instr[15:0]};

  //////////////////////////////////////////////////////////////////////
  // Next PC, the delay slot is already in fetch

  assign d_pc_plus4 = d_pc + 32'd4;
  assign beq_target = d_pc_plus4 + {imm_ext[29:0], 2'b00};

  always_comb begin
    if (is_jr) begin
      pc_next = rs_val;
    end else if (is_jump) begin
      pc_next = {d_pc_plus4[31:28], d_instr[25:0], 2'b00};
    end else if (is_beq && (rs_val == rt_val)) begin
      pc_next = beq_target;
    end else begin
      pc_next = pc + 32'd4;
    end
  end

  // Bubble into execute while stalled
  assign e_in_wr_addr  = stall ? '0 : wr_addr;
  assign e_in_rs_val   = rs_val;
  assign e_in_rt_val   = rt_val;
  assign e_in_imm      = imm_ext;
  assign e_in_alu_op   = alu_op;
  assign e_in_b_is_imm = b_is_imm;
  assign e_in_rs       = d_rs;
  assign e_in_rt       = d_rt;
  assign e_in_link     = is_link;
  assign e_in_link_val = d_pc + 32'd8;
  assign e_in_pc       = d_pc;

endmodule

// ==== rtl/execute_stage.sv ====
`timescale 1ns/1ps

module execute_stage import cpu_pkg::*; (
  input  logic      clk,
  input  logic      rst,
  input  word_t     e_in_rs_val,
  input  word_t     e_in_rt_val,
  input  word_t     e_in_imm,
  input  alu_op_t   e_in_alu_op,
  input  logic      e_in_b_is_imm,
  input  reg_addr_t e_in_wr_addr,
  input  reg_addr_t e_in_rs,
  input  reg_addr_t e_in_rt,
  input  logic      e_in_link,
  input  word_t     e_in_link_val,
  input  word_t     e_in_pc,
  input  logic      fwd_rs,
  input  logic      fwd_rt,
  input  word_t     res_wdata,
  output reg_addr_t e_rs,
  output reg_addr_t e_rt,
  output reg_addr_t e_wr_addr,
  output word_t     r_in_result,
  output reg_addr_t r_in_wr_addr,
  output logic      r_in_link,
  output word_t     r_in_link_val,
  output word_t     r_in_pc
);

  word_t     rs_val_q;
  word_t     rt_val_q;
  word_t     imm_q;
  alu_op_t   alu_op_q;
  logic      b_is_imm_q;
  reg_addr_t wr_addr_q;
  reg_addr_t rs_q;
  reg_addr_t rt_q;
  logic      link_q;
  word_t     link_val_q;
  word_t     pc_q;
  word_t     a;
  word_t     rt_fwd;
  word_t     b;
  word_t     alu_y;

  //////////////////////////////////////////////////////////////////////
  // Decode/execute register

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_addr_q <= '0;
      link_q    <= 1'b0;
    end else begin
      wr_addr_q <= e_in_wr_addr;
      link_q    <= e_in_link;
    end
  end

  always_ff @(posedge clk) begin
    rs_val_q   <= e_in_rs_val;
    rt_val_q   <= e_in_rt_val;
    imm_q      <= e_in_imm;
    alu_op_q   <= e_in_alu_op;
    b_is_imm_q <= e_in_b_is_imm;
    rs_q       <= e_in_rs;
    rt_q       <= e_in_rt;
    link_val_q <= e_in_link_val;
    pc_q       <= e_in_pc;
  end

  //////////////////////////////////////////////////////////////////////
  // Operands and ALU

  // Previous instruction sits in result
  assign a      = fwd_rs ? res_wdata : rs_val_q;
  assign rt_fwd = fwd_rt ? res_wdata : rt_val_q;
  assign b      = b_is_imm_q ? imm_q : rt_fwd;

  always_comb begin
    case (alu_op_q)
      ALU_SUB: alu_y = a - b;
      ALU_AND: alu_y = a & b;
      ALU_OR:  alu_y = a | b;
      ALU_SLT: alu_y = {31'b0, $signed(a) < $signed(b)};
      ALU_LUI: alu_y = {b[15:0], 16'h0000};
      default: alu_y = a + b;
    endcase
  end

  assign e_rs          = rs_q;
  assign e_rt          = rt_q;
  assign e_wr_addr     = wr_addr_q;
  assign r_in_result   = alu_y;
  assign r_in_wr_addr  = wr_addr_q;
  assign r_in_link     = link_q;
  assign r_in_link_val = link_val_q;
  assign r_in_pc       = pc_q;

endmodule

// ==== rtl/hazard_unit.sv ====
`timescale 1ns/1ps

module hazard_unit import cpu_pkg::*; (
  input  reg_addr_t d_rs,
  input  reg_addr_t d_rt,
  input  logic      d_uses_rs,
  input  logic      d_uses_rt,
  input  reg_addr_t e_rs,
  input  reg_addr_t e_rt,
  input  reg_addr_t e_wr_addr,
  input  reg_addr_t res_wr_addr,
  output logic      stall,
  output logic      fwd_d_rs,
  output logic      fwd_d_rt,
  output logic      fwd_e_rs,
  output logic      fwd_e_rt
);

  logic e_hit_rs;
  logic e_hit_rt;

  // $0 is never a real producer
  function automatic logic hit(input reg_addr_t src, input reg_addr_t dst);
    return (dst != '0) && (src == dst);
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Stall

  // Execute result not ready for a decode-time compare or jump
  assign e_hit_rs = d_uses_rs && hit(d_rs, e_wr_addr);
  assign e_hit_rt = d_uses_rt && hit(d_rt, e_wr_addr);
  assign stall    = e_hit_rs || e_hit_rt;

  //////////////////////////////////////////////////////////////////////
  // Forwarding from the result stage

  // Into decode, any reader, the register file is written one edge late
  assign fwd_d_rs = hit(d_rs, res_wr_addr);
  assign fwd_d_rt = hit(d_rt, res_wr_addr);

  // Into execute
  assign fwd_e_rs = hit(e_rs, res_wr_addr);
  assign fwd_e_rt = hit(e_rt, res_wr_addr);

endmodule

// ==== rtl/instr_decoder.sv ====
`timescale 1ns/1ps

module instr_decoder import cpu_pkg::*; (
  input  instr_t    instr,
  output alu_op_t   alu_op,
  output logic      b_is_imm,
  output logic      imm_zero_ext,
  output reg_addr_t wr_addr,
  output logic      is_link,
  output logic      is_beq,
  output logic      is_jump,
  output logic      is_jr,
  output logic      uses_rs_in_decode,
  output logic      uses_rt_in_decode
);

  opcode_t   opcode;
  funct_t    funct;
  reg_addr_t rt;
  reg_addr_t rd;

  assign opcode = instr[31:26];
  assign funct  = instr[5:0];
  assign rt     = instr[20:16];
  assign rd     = instr[15:11];

  // Defaults describe a nop, anything unknown falls through to it
  always_comb begin
    alu_op       = ALU_ADD;
    b_is_imm     = 1'b0;
    imm_zero_ext = 1'b0;
    wr_addr      = '0;
    is_link      = 1'b0;
    is_beq       = 1'b0;
    is_jump      = 1'b0;
    is_jr        = 1'b0;
    case (opcode)
      OP_SPECIAL: begin
        // R-type writes rd
        case (funct)
          FN_ADDU: wr_addr = rd;
          FN_SUBU: begin
            alu_op  = ALU_SUB;
            wr_addr = rd;
          end
          FN_AND: begin
            alu_op  = ALU_AND;
            wr_addr = rd;
          end
          FN_OR: begin
            alu_op  = ALU_OR;
            wr_addr = rd;
          end
          FN_SLT: begin
            alu_op  = ALU_SLT;
            wr_addr = rd;
          end
          FN_JR:   is_jr = 1'b1;
          default: ;
        endcase
      end
      OP_ORI: begin
        alu_op       = ALU_OR;
        b_is_imm     = 1'b1;
        imm_zero_ext = 1'b1;
        wr_addr      = rt;
      end
      OP_LUI: begin
        alu_op       = ALU_LUI;
        b_is_imm     = 1'b1;
        imm_zero_ext = 1'b1;
        wr_addr      = rt;
      end
      OP_BEQ: is_beq = 1'b1;
      OP_J:   is_jump = 1'b1;
      OP_JAL: begin
        is_jump = 1'b1;
        is_link = 1'b1;
        wr_addr = LINK_REG;
      end
      default: ;
    endcase
  end

  // Registers needed already in decode
  assign uses_rs_in_decode = is_beq | is_jr;
  assign uses_rt_in_decode = is_beq;

endmodule

// ==== rtl/result_stage.sv ====
`timescale 1ns/1ps

module result_stage import cpu_pkg::*; (
  input  logic      clk,
  input  logic      rst,
  input  word_t     r_in_result,
  input  reg_addr_t r_in_wr_addr,
  input  logic      r_in_link,
  input  word_t     r_in_link_val,
  input  word_t     r_in_pc,
  input  reg_addr_t rf_raddr1,
  input  reg_addr_t rf_raddr2,
  output word_t     rf_rdata1,
  output word_t     rf_rdata2,
  output reg_addr_t res_wr_addr,
  output word_t     res_wdata,
  output logic      grf_we,
  output word_t     grf_pc
);

  word_t     result_q;
  reg_addr_t wr_addr_q;
  logic      link_q;
  word_t     link_val_q;
  word_t     pc_q;
  word_t     regs [1:31];

  //////////////////////////////////////////////////////////////////////
  // Execute/result register

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_addr_q <= '0;
      link_q    <= 1'b0;
    end else begin
      wr_addr_q <= r_in_wr_addr;
      link_q    <= r_in_link;
    end
  end

  always_ff @(posedge clk) begin
    result_q   <= r_in_result;
    link_val_q <= r_in_link_val;
    pc_q       <= r_in_pc;
  end

  // jal writes its return address
  assign res_wdata   = link_q ? link_val_q : result_q;
  assign res_wr_addr = wr_addr_q;
  assign grf_we      = (wr_addr_q != '0);
  assign grf_pc      = pc_q;

  //////////////////////////////////////////////////////////////////////
  // Register file, written at the edge that ends the result cycle

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (grf_we) begin
      regs[wr_addr_q] <= res_wdata;
    end
  end

  assign rf_rdata1 = (rf_raddr1 == '0) ? '0 : regs[rf_raddr1];
  assign rf_rdata2 = (rf_raddr2 == '0) ? '0 : regs[rf_raddr2];

endmodule

// ==== run.sh ====
#!/usr/bin/env bash
# Compile and run tb_cpu with Verilator, then look for the fail message in the log

cd "$(dirname "$0")" || exit 1
LOG=sim.log
rm -f "$LOG"

verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module tb_cpu -f all.f --Mdir obj_dir -o Vtb_cpu >> "$LOG" 2>&1 \
  && ./obj_dir/Vtb_cpu >> "$LOG" 2>&1 \
  || echo "TB FAILED" >> "$LOG"

cat "$LOG"
grep -q "TB FAILED" "$LOG" && exit 1 || exit 0

// ==== verif/cpu_chk.sv ====
`timescale 1ns/1ps

module cpu_chk import cpu_pkg::*; (
  input logic      clk,
  input logic      rst,
  input word_t     inst_addr,
  input logic      grf_we,
  input reg_addr_t grf_addr,
  input logic      stall
);

  // $0 is never a write target
  a_no_zero_write: assert property (@(posedge clk) disable iff (rst)
    grf_we |-> (grf_addr != '0))
    else $error("trace shows a register write to $0");

  // Quiet once reset has been seen on an edge
  a_quiet_in_reset: assert property (@(posedge clk)
    (rst && $past(rst)) |-> !grf_we)
    else $error("register write while reset is held");

  a_fetch_aligned: assert property (@(posedge clk) disable iff (rst)
    inst_addr[1:0] == 2'b00)
    else $error("fetch address is not word aligned");

  // Only one producer can sit in execute
  a_stall_one_cycle: assert property (@(posedge clk) disable iff (rst)
    stall |=> !stall)
    else $error("decode stall held for two cycles");

endmodule

bind cpu_top cpu_chk u_chk (
  .clk       (clk),
  .rst       (rst),
  .inst_addr (inst_addr),
  .grf_we    (grf_we),
  .grf_addr  (grf_addr),
  .stall     (stall)
);

// ==== verif/tb_cpu.sv ====
`timescale 1ns/1ps

module tb_cpu import cpu_pkg::*; ();

  localparam word_t RESET_PC     = 32'h0000_3000;
  localparam int    CLK_PERIOD   = 40;
  localparam int    RESET_CYCLES = 10;
  localparam int    PROG_TARGET  = 200;
  localparam int    MEM_WORDS    = 256;
  // Pipeline depth plus one stall
  localparam int    DRAIN_CYCLES = 4;

  logic        clk;
  logic        rst;
  instr_t      inst_rdata;
  word_t       inst_addr;
  logic        grf_we;
  reg_addr_t   grf_addr;
  word_t       grf_wdata;
  word_t       grf_pc;

  instr_t      imem [0:MEM_WORDS-1];
  int          prog_len = 0;
  logic        prog_ready = 1'b0;
  word_t       end_pc;
  word_t       fetch_off;
  word_t       ref_pc, ref_npc;
  word_t       ref_regs [0:31];
  word_t       exp_pc [$];
  reg_addr_t   exp_addr [$];
  word_t       exp_data [$];
  int unsigned lcg_state = 32'd11241;
  int          value_errors = 0;
  int          other_errors = 0;
  int          writes_seen = 0;

  cpu_top #(.RESET_PC(RESET_PC)) dut (
    .clk        (clk),
    .rst        (rst),
    .inst_rdata (inst_rdata),
    .inst_addr  (inst_addr),
    .grf_we     (grf_we),
    .grf_addr   (grf_addr),
    .grf_wdata  (grf_wdata),
    .grf_pc     (grf_pc)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // Instruction memory answers in the same cycle
  // Fetches outside the program return a nop
  assign fetch_off  = inst_addr - RESET_PC;
  assign inst_rdata = (fetch_off[31:2] < 30'(prog_len)) ? imem[fetch_off[9:2]] : '0;

  //////////////////////////////////////////////////////////////////////
  // Random program

  function automatic int unsigned lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
  endfunction

  function automatic int unsigned rand_below(input int unsigned n);
    return (lcg_next() >> 16) % n;
  endfunction

  function automatic word_t addr_of(input int idx);
    return RESET_PC + word_t'(idx) * 32'd4;
  endfunction

  function automatic instr_t rtype_word(input funct_t fn, input reg_addr_t rd,
                                        input reg_addr_t rs, input reg_addr_t rt);
    return {OP_SPECIAL, rs, rt, rd, 5'd0, fn};
  endfunction

  function automatic instr_t itype_word(input opcode_t op, input reg_addr_t rt,
                                        input reg_addr_t rs, input logic [15:0] imm);
    return {op, rs, rt, imm};
  endfunction

  function automatic instr_t jump_word(input opcode_t op, input word_t target);
    return {op, target[27:2]};
  endfunction

  // Registers 0..7 only so that neighbours depend on each other often
  function automatic instr_t random_alu();
    reg_addr_t   rd, rs, rt;
    logic [15:0] imm;
    instr_t      w;
    rd  = reg_addr_t'(rand_below(8));
    rs  = reg_addr_t'(rand_below(8));
    rt  = reg_addr_t'(rand_below(8));
    imm = 16'(lcg_next() >> 8);
    case (rand_below(10))
      0:       w = rtype_word(FN_ADDU, rd, rs, rt);
      1:       w = rtype_word(FN_SUBU, rd, rs, rt);
      2:       w = rtype_word(FN_AND, rd, rs, rt);
      3:       w = rtype_word(FN_OR, rd, rs, rt);
      4:       w = rtype_word(FN_SLT, rd, rs, rt);
      5:       w = itype_word(OP_ORI, rd, rs, imm);
      6:       w = itype_word(OP_LUI, rd, 5'd0, imm);
      7:       w = '0;
      // lw is not in the kept set
      8:       w = {6'b100011, rs, rt, imm};
      // sll with a real rd is also a nop here
      default: w = rtype_word(6'b000000, rd, 5'd0, rt);
    endcase
    return w;
  endfunction

  task automatic put_instr(input instr_t w);
    imem[prog_len[7:0]] = w;
    prog_len++;
  endtask

  task automatic build_program();
    int unsigned kind, fill;
    reg_addr_t   ra, rb;
    word_t       here;
    while (prog_len < PROG_TARGET) begin
      kind = rand_below(10);
      here = addr_of(prog_len);
      fill = 1 + rand_below(3);
      if (kind < 6) begin
        put_instr(random_alu());
      end else if (kind < 8) begin
        // Producer right before beq forces the decode stall
        ra = reg_addr_t'(rand_below(8));
        rb = (rand_below(3) == 0) ? ra : reg_addr_t'(rand_below(8));
        put_instr(rtype_word(FN_OR, ra, reg_addr_t'(rand_below(8)), reg_addr_t'(rand_below(8))));
        put_instr(itype_word(OP_BEQ, rb, ra, 16'(fill + 1)));
        repeat (fill + 1) put_instr(random_alu());
      end else if (kind < 9) begin
        put_instr(jump_word((rand_below(2) == 0) ? OP_J : OP_JAL, here + 32'd8 + fill * 4));
        repeat (fill + 1) put_instr(random_alu());
      end else begin
        // Call a two-word routine then come back and jump over it
        put_instr(jump_word(OP_JAL, here + 32'd16));
        put_instr(random_alu());
        put_instr(jump_word(OP_J, here + 32'd28));
        put_instr(random_alu());
        put_instr(rtype_word(FN_OR, LINK_REG, LINK_REG, 5'd0));
        put_instr(rtype_word(FN_JR, 5'd0, LINK_REG, 5'd0));
        put_instr(random_alu());
      end
    end
    end_pc = addr_of(prog_len);
    put_instr(jump_word(OP_J, end_pc));
    put_instr('0);
  endtask

  //////////////////////////////////////////////////////////////////////
  // Reference interpreter stepping one instruction per call

  function automatic void ref_step();
    instr_t    w;
    word_t     off, slot_pc, a, b, val, npc_next;
    reg_addr_t dst;
    off      = ref_pc - RESET_PC;
    w        = imem[off[9:2]];
    slot_pc  = ref_pc + 32'd4;
    a        = ref_regs[w[25:21]];
    b        = ref_regs[w[20:16]];
    dst      = '0;
    val      = '0;
    npc_next = ref_npc + 32'd4;
    case (w[31:26])
      OP_SPECIAL: begin
        case (w[5:0])
          FN_ADDU: {dst, val} = {w[15:11], a + b};
          FN_SUBU: {dst, val} = {w[15:11], a - b};
          FN_AND:  {dst, val} = {w[15:11], a & b};
          FN_OR:   {dst, val} = {w[15:11], a | b};
          FN_SLT:  {dst, val} = {w[15:11], ($signed(a) < $signed(b)) ? 32'd1 : 32'd0};
          FN_JR:   npc_next = a;
          default: ;
        endcase
      end
      OP_ORI: {dst, val} = {w[20:16], a | {16'h0000, w[15:0]}};
      OP_LUI: {dst, val} = {w[20:16], w[15:0], 16'h0000};
      OP_BEQ: begin
        if (a == b) npc_next = slot_pc + {{14{w[15]}}, w[15:0], 2'b00};
      end
      OP_J:   npc_next = {slot_pc[31:28], w[25:0], 2'b00};
      OP_JAL: begin
        npc_next   = {slot_pc[31:28], w[25:0], 2'b00};
        {dst, val} = {LINK_REG, ref_pc + 32'd8};
      end
      default: ;
    endcase
    // $0 stays zero and makes no write event
    if (dst != '0) begin
      ref_regs[dst] = val;
      exp_pc.push_back(ref_pc);
      exp_addr.push_back(dst);
      exp_data.push_back(val);
    end
    ref_pc  = ref_npc;
    ref_npc = npc_next;
  endfunction

  task automatic build_expected();
    int steps;
    steps   = 0;
    ref_pc  = RESET_PC;
    ref_npc = RESET_PC + 32'd4;
    for (int i = 0; i < 32; i++) ref_regs[i] = '0;
    while (ref_pc != end_pc && steps < 4 * MEM_WORDS) begin
      ref_step();
      steps++;
    end
    if (ref_pc != end_pc) begin
      $display("Reference run never reached the end loop");
      other_errors++;
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Checking

  task automatic check_addr(input string what, input reg_addr_t got, input reg_addr_t exp);
    if (got !== exp) begin
      $display("ERR %0t: %s is %0d, expected %0d", $time, what, got, exp);
      value_errors++;
    end
  endtask

  task automatic check_word(input string what, input word_t got, input word_t exp);
    if (got !== exp) begin
      $display("ERR %0t: %s is %h, expected %h", $time, what, got, exp);
      value_errors++;
    end
  endtask

  always @(posedge clk) begin
    if (!rst && grf_we) begin
      writes_seen++;
      if (exp_addr.size() == 0) begin
        $display("Register write to r%0d at %0t when no write was expected", grf_addr, $time);
        other_errors++;
      end else begin
        check_addr("write address", grf_addr, exp_addr.pop_front());
        check_word("write data", grf_wdata, exp_data.pop_front());
        check_word("write pc", grf_pc, exp_pc.pop_front());
      end
    end
  end

  initial begin
    rst = 1'b1;
    build_program();
    build_expected();
    prog_ready = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk);
    rst <= 1'b0;
    // First fetch once reset has been released
    @(negedge clk);
    check_word("fetch address after reset", inst_addr, RESET_PC);
    while (inst_addr != end_pc) @(posedge clk);
    repeat (DRAIN_CYCLES) @(posedge clk);
    @(negedge clk);
    if (exp_addr.size() != 0) begin
      $display("%0d expected register writes never appeared", exp_addr.size());
      other_errors++;
    end
    $display("Writes seen %0d, value errors %0d, other errors %0d",
             writes_seen, value_errors, other_errors);
    if (value_errors == 0 && other_errors == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

  // Watchdog allows two cycles per instruction plus margin
  initial begin
    wait (prog_ready);
    #((prog_len * 2 + 50) * CLK_PERIOD);
    $display("Timeout: end loop not reached within %0d cycles", prog_len * 2 + 50);
    $display("TB FAILED");
    $finish;
  end

endmodule
